/* rtl/tour_config.svh */
`ifndef TOUR_CONFIG_SVH
`define TOUR_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Tour geometry
////////////////////////////////////////////////////////////////////////////
`define TOUR_MOVES 24         // Moves in one full tour
`define MV_IDX_W 5            // Enough bits to index TOUR_MOVES entries

////////////////////////////////////////////////////////////////////////////
// Command processor encodings
////////////////////////////////////////////////////////////////////////////
`define OP_MOVE 4'h4          // Plain move
`define OP_FANFARE 4'h5       // Move, then play fanfare

`define HEAD_NORTH 8'h00      // Heading codes as the processor expects them
`define HEAD_WEST 8'h3F
`define HEAD_SOUTH 8'h7F
`define HEAD_EAST 8'hBF

// Response bytes sent back after each command
`define RESP_DONE 8'hA5       // Tour finished, or a plain serial command
`define RESP_BUSY 8'h5A       // Tour still running

`endif

/* rtl/tour_pkg.sv */
package tour_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Command word, one 16-bit word seen two ways
  ////////////////////////////////////////////////////////////////////////////

  // Generic view, opcode plus opaque payload
  typedef struct packed {
    logic [3:0]  opcode;            // [15:12]
    logic [11:0] payload;           // [11:0], not interpreted here
  } cmd_raw_t;

  // Movement view built by the sequencer
  typedef struct packed {
    logic [3:0] opcode;             // [15:12]
    logic [7:0] heading;            // [11:4] heading code
    logic [3:0] num_sq;             // [3:0] squares to travel
  } cmd_move_t;

  typedef union packed {
    cmd_raw_t  raw;                 // Serial and pass-through path
    cmd_move_t mv;                  // Tour path
  } cmd_word_u;

  ////////////////////////////////////////////////////////////////////////////
  // Request and status bundles
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    cmd_word_u word;                // Command word
    logic      rdy;                 // Level, held until cleared
  } cmd_req_t;

  typedef struct packed {
    logic active;                   // Sequencer is mid-tour
    logic last;                     // Current command is the final horizontal one
  } tour_status_t;

  // Sequencer states, hold states wait for send_resp
  typedef enum logic [2:0] {
    IDLE,
    VERT,
    HOLDV,
    HORZ,
    HOLDH
  } tour_state_t;

endpackage

/* rtl/cmd_byte_assembler.sv */
module cmd_byte_assembler (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [7:0]         rx_byte,       // Byte from the serial receiver
  input  logic               rx_rdy,        // One-cycle strobe per byte
  input  logic               clr_cmd_rdy,   // Command consumed
  output tour_pkg::cmd_req_t uart_req       // Assembled command and ready level
);
  import tour_pkg::*;

  logic       lo_phase;       // High when the next byte is the low half
  logic [7:0] high_byte;      // First byte of the pair
  cmd_word_u  word_q;         // Completed command
  logic       rdy_q;          // Command waiting to be taken
  logic       take_byte;      // Accept this strobe
  logic       set_rdy;        // Low byte arrives, word is complete

  // Bytes are dropped while a command is still pending
  assign take_byte = rx_rdy & ~rdy_q;
  assign set_rdy   = take_byte & lo_phase;

  ////////////////////////////////////////////////////////////////////////////
  // Byte sequencing
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      lo_phase <= 1'b0;                 // Always start on a high byte
    else if (take_byte)
      lo_phase <= ~lo_phase;            // Alternate high, low
  end

  always_ff @(posedge clk) begin
    if (take_byte & ~lo_phase)
      high_byte <= rx_byte;             // Park the high byte
  end

  always_ff @(posedge clk) begin
    if (set_rdy) begin
      word_q.raw.opcode  <= high_byte[7:4];
      word_q.raw.payload <= {high_byte[3:0], rx_byte};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Ready level
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      rdy_q <= 1'b0;
    else if (set_rdy)
      rdy_q <= 1'b1;                    // Rises the cycle after the low byte
    else if (clr_cmd_rdy)
      rdy_q <= 1'b0;                    // Processor took it
  end

  assign uart_req.word = word_q;
  assign uart_req.rdy  = rdy_q;

  // The processor only clears a command it was shown, so a clear can never
  // meet a freshly completed word
  a_set_clr_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !(set_rdy && clr_cmd_rdy))
    else $error("cmd_byte_assembler: rdy set and cleared in one cycle");

endmodule

/* rtl/move_store.sv */
`include "tour_config.svh"

module move_store (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load_we,       // Write strobe from the loader
  input  logic [`MV_IDX_W-1:0] load_addr,     // Entry to write
  input  logic [7:0]           load_move,     // One-hot move to store
  input  logic [`MV_IDX_W-1:0] mv_indx,       // Read index from the sequencer
  output logic [7:0]           move          // Move at mv_indx
);

  logic [7:0] mem [`TOUR_MOVES];   // One entry per tour step

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (load_we)
      mem[load_addr] <= load_move;     // Table is loaded before the tour
  end

  // Asynchronous read, sequencer decodes in the same cycle
  assign move = mem[mv_indx];

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Decoder in tour_cmd relies on exactly one bit set
  a_load_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    load_we |-> $onehot(load_move))
    else $error("move_store: loaded move %h is not one-hot", load_move);

  // Both ports must stay inside the table
  a_load_range : assert property (@(posedge clk) disable iff (!rst_n)
    load_we |-> (int'(load_addr) < `TOUR_MOVES))
    else $error("move_store: load_addr %0d out of range", load_addr);

  // Sequencer stops at the last entry and never runs past it
  a_read_range : assert property (@(posedge clk) disable iff (!rst_n)
    int'(mv_indx) < `TOUR_MOVES)
    else $error("move_store: mv_indx %0d out of range", mv_indx);

endmodule

/* rtl/tour_cmd.sv */
`include "tour_config.svh"

module tour_cmd (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start_tour,    // Pulse once the table is loaded
  input  logic                   clr_cmd_rdy,   // Processor took the command
  input  logic                   send_resp,     // Processor finished the command
  input  logic [7:0]             move,          // One-hot move at mv_indx
  input  tour_pkg::cmd_req_t     uart_req,      // Serial command
  output logic [`MV_IDX_W-1:0]   mv_indx,       // Current tour step
  output tour_pkg::cmd_req_t     sel_req,       // Command toward the processor
  output tour_pkg::tour_status_t status         // Tour progress for responses
);
  import tour_pkg::*;

  localparam int LAST_IDX = `TOUR_MOVES - 1;

  tour_state_t state, nxt_state;
  logic        clr_cnt;       // Restart the move index
  logic        inc_cnt;       // Advance to the next move
  logic        set_rdy;       // Entering a command state
  logic        tour_rdy;      // Ready level for tour commands
  logic        horz_phase;    // Horizontal half of the move
  logic        last_move;     // Index is at the final move
  logic [7:0]  v_head;        // Vertical heading
  logic [3:0]  v_num;         // Vertical distance
  logic [7:0]  h_head;        // Horizontal heading
  logic [3:0]  h_num;         // Horizontal distance
  cmd_word_u   tour_word;
  cmd_req_t    tour_req;

  assign horz_phase = (state == HORZ) || (state == HOLDH);
  assign last_move  = (mv_indx == LAST_IDX[`MV_IDX_W-1:0]);

  ////////////////////////////////////////////////////////////////////////////
  // State, index and ready registers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      mv_indx <= '0;
    else if (clr_cnt)
      mv_indx <= '0;                    // New tour starts at move 0
    else if (inc_cnt)
      mv_indx <= mv_indx + 1'b1;
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      tour_rdy <= 1'b0;
    else if (set_rdy)
      tour_rdy <= 1'b1;                 // High in the first cycle of VERT or HORZ
    else if (clr_cmd_rdy)
      tour_rdy <= 1'b0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Transitions
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    nxt_state = state;
    clr_cnt   = 1'b0;
    inc_cnt   = 1'b0;
    set_rdy   = 1'b0;
    case (state)
      IDLE: begin
        if (start_tour) begin           // Only honored here
          clr_cnt   = 1'b1;
          set_rdy   = 1'b1;
          nxt_state = VERT;
        end
      end
      VERT: begin
        if (clr_cmd_rdy)
          nxt_state = HOLDV;            // Wait for the vertical leg to finish
      end
      HOLDV: begin
        if (send_resp) begin
          set_rdy   = 1'b1;
          nxt_state = HORZ;
        end
      end
      HORZ: begin
        if (clr_cmd_rdy)
          nxt_state = HOLDH;
      end
      HOLDH: begin
        if (send_resp) begin
          if (last_move) begin
            nxt_state = IDLE;           // Index stays on the last entry
          end else begin
            inc_cnt   = 1'b1;
            set_rdy   = 1'b1;
            nxt_state = VERT;
          end
        end
      end
      default: nxt_state = IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Move decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    v_head = `HEAD_NORTH;
    v_num  = 4'h0;
    h_head = `HEAD_EAST;
    h_num  = 4'h0;
    case (move)
      8'h01: {v_head, v_num, h_head, h_num} = {`HEAD_NORTH, 4'h2, `HEAD_EAST, 4'h1};
      8'h02: {v_head, v_num, h_head, h_num} = {`HEAD_NORTH, 4'h2, `HEAD_WEST, 4'h1};
      8'h04: {v_head, v_num, h_head, h_num} = {`HEAD_NORTH, 4'h1, `HEAD_WEST, 4'h2};
      8'h08: {v_head, v_num, h_head, h_num} = {`HEAD_SOUTH, 4'h1, `HEAD_WEST, 4'h2};
      8'h10: {v_head, v_num, h_head, h_num} = {`HEAD_SOUTH, 4'h2, `HEAD_WEST, 4'h1};
      8'h20: {v_head, v_num, h_head, h_num} = {`HEAD_SOUTH, 4'h2, `HEAD_EAST, 4'h1};
      8'h40: {v_head, v_num, h_head, h_num} = {`HEAD_SOUTH, 4'h1, `HEAD_EAST, 4'h2};
      8'h80: {v_head, v_num, h_head, h_num} = {`HEAD_NORTH, 4'h1, `HEAD_EAST, 4'h2};
      default: ;                        // Illegal move leaves zero distance
    endcase
  end

  always_comb begin
    tour_word.mv.opcode  = horz_phase ? `OP_FANFARE : `OP_MOVE;
    tour_word.mv.heading = horz_phase ? h_head : v_head;
    tour_word.mv.num_sq  = horz_phase ? h_num : v_num;
  end

  assign tour_req.word = tour_word;
  assign tour_req.rdy  = tour_rdy;

  // Serial commands pass through untouched outside a tour
  assign sel_req = (state == IDLE) ? uart_req : tour_req;

  assign status.active = (state != IDLE);
  assign status.last   = horz_phase & last_move;

  // The table must have been loaded with legal moves before start_tour
  a_move_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    (state != IDLE) |-> $onehot(move))
    else $error("tour_cmd: move %h at index %0d is not one-hot", move, mv_indx);

endmodule

/* rtl/cmd_issue.sv */
`include "tour_config.svh"

module cmd_issue (
  input  logic                   clk,
  input  logic                   rst_n,
  input  tour_pkg::cmd_req_t     sel_req,     // Selected command
  input  tour_pkg::tour_status_t status,      // Tour progress
  input  logic                   send_resp,   // Processor finished a command
  output logic [15:0]            cmd,         // Command to the processor
  output logic                   cmd_rdy,     // Command waiting
  output logic                   resp_vld,    // Response byte valid
  output logic [7:0]             resp         // Response byte
);

  logic [7:0] resp_sel;       // Byte picked for this send_resp

  ////////////////////////////////////////////////////////////////////////////
  // Command register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    cmd <= sel_req.word.raw;            // One cycle behind the selection
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      cmd_rdy <= 1'b0;
    else
      cmd_rdy <= sel_req.rdy;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////////////////////

  // Busy only mid-tour, the closing horizontal leg reports done
  assign resp_sel = (status.active && !status.last) ? `RESP_BUSY : `RESP_DONE;

  always_ff @(posedge clk) begin
    if (send_resp)
      resp <= resp_sel;                 // Held until the next response
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      resp_vld <= 1'b0;
    else
      resp_vld <= send_resp;            // Exactly one cycle after send_resp
  end

  // One response per command, never a stretched strobe
  a_resp_pulse : assert property (@(posedge clk) disable iff (!rst_n)
    resp_vld |=> !resp_vld)
    else $error("cmd_issue: resp_vld high for two cycles");

endmodule

/* rtl/knight_tour_top.sv */
`include "tour_config.svh"

module knight_tour_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [7:0]           rx_byte,       // Serial byte
  input  logic                 rx_rdy,        // Serial byte strobe
  input  logic                 load_we,       // Move table write
  input  logic [`MV_IDX_W-1:0] load_addr,
  input  logic [7:0]           load_move,
  input  logic                 start_tour,    // From the processor
  input  logic                 clr_cmd_rdy,
  input  logic                 send_resp,
  output logic [15:0]          cmd,           // To the processor
  output logic                 cmd_rdy,
  output logic [7:0]           resp,
  output logic                 resp_vld
);
  import tour_pkg::*;

  cmd_req_t             uart_req;     // Assembled serial command
  cmd_req_t             sel_req;      // Command chosen by the sequencer
  tour_status_t         status;       // Tour progress
  logic [`MV_IDX_W-1:0] mv_indx;      // Current step
  logic [7:0]           move;         // Move at that step
  logic                 uart_clr;     // Clear aimed at the serial command

  // Mid-tour clears belong to tour commands, a pending serial command waits
  assign uart_clr = clr_cmd_rdy & ~status.active;

  ////////////////////////////////////////////////////////////////////////////
  // Input side, sequencer, output side
  ////////////////////////////////////////////////////////////////////////////
  cmd_byte_assembler i_asm (
    .clk, .rst_n, .rx_byte, .rx_rdy, .clr_cmd_rdy(uart_clr), .uart_req
  );

  move_store i_store (
    .clk, .rst_n, .load_we, .load_addr, .load_move, .mv_indx, .move
  );

  tour_cmd i_seq (
    .clk, .rst_n, .start_tour, .clr_cmd_rdy, .send_resp, .move, .uart_req,
    .mv_indx, .sel_req, .status
  );

  cmd_issue i_issue (
    .clk, .rst_n, .sel_req, .status, .send_resp, .cmd, .cmd_rdy, .resp_vld, .resp
  );

endmodule

/* testbench/tb_knight_tour.sv */
`include "tour_config.svh"

module tb_knight_tour;
  import tour_pkg::*;

  localparam int WAIT_LIMIT = 200;            // Cycles allowed for any handshake
  localparam logic [15:0] SERIAL_CMD = 16'h3A5C;
  localparam logic [15:0] SERIAL_MID = 16'h7C3E;

  logic                 clk;
  logic                 rst_n;
  logic [7:0]           rx_byte;
  logic                 rx_rdy;
  logic                 load_we;
  logic [`MV_IDX_W-1:0] load_addr;
  logic [7:0]           load_move;
  logic                 start_tour;
  logic                 clr_cmd_rdy;
  logic                 send_resp;
  logic [15:0]          cmd;
  logic                 cmd_rdy;
  logic [7:0]           resp;
  logic                 resp_vld;

  int          seed;
  int          errors;
  int          tests;
  int          test_err0;                     // Error count when the test began
  string       test_name;
  logic [7:0]  table_q [`TOUR_MOVES];         // Copy of the loaded move table
  logic [15:0] exp_cmd_q [$];                 // Expected commands, in order
  logic [7:0]  exp_resp_q [$];                // Expected response bytes
  string       cmd_lbl_q [$];
  string       resp_lbl_q [$];
  logic        cmd_rdy_seen;

  knight_tour_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and checking
  ////////////////////////////////////////////////////////////////////////////

  // Expected {command, response} for one leg of a knight move
  function automatic logic [23:0] expect_step(input logic [7:0] mv, input logic horz,
                                              input int idx);
    int          b;
    logic        north;
    logic        east;
    logic [3:0]  vdist;
    logic [3:0]  hdist;
    cmd_word_u   word;
    logic [7:0]  rsp;
    b = 0;
    for (int k = 0; k < 8; k++)
      if (mv[k]) b = k;                        // Position of the one-hot bit
    north = (b <= 2) || (b == 7);
    east  = (b == 0) || (b >= 5);
    vdist = (b == 0 || b == 1 || b == 4 || b == 5) ? 4'd2 : 4'd1;
    hdist = 4'd3 - vdist;                      // A knight covers three squares
    if (horz) begin
      word.mv.opcode  = `OP_FANFARE;
      word.mv.heading = east ? `HEAD_EAST : `HEAD_WEST;
      word.mv.num_sq  = hdist;
    end else begin
      word.mv.opcode  = `OP_MOVE;
      word.mv.heading = north ? `HEAD_NORTH : `HEAD_SOUTH;
      word.mv.num_sq  = vdist;
    end
    rsp = (horz && idx == `TOUR_MOVES - 1) ? `RESP_DONE : `RESP_BUSY;
    return {word, rsp};
  endfunction

  task automatic check(input string label, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("mismatch %s %s: expected %0h actual %0h", test_name, label, exp, act);
      errors++;
    end
  endtask

  task automatic report_fail(input string why);
    $display("error in %s: %s", test_name, why);
    errors++;
  endtask

  // Compares every new command and every response against the queues
  always @(negedge clk) begin
    if (rst_n) begin
      if (cmd_rdy && !cmd_rdy_seen) begin
        if (exp_cmd_q.size() == 0)
          report_fail("a command appeared that nothing expected");
        else
          check(cmd_lbl_q.pop_front(), 32'(exp_cmd_q.pop_front()), 32'(cmd));
      end
      if (resp_vld) begin
        if (exp_resp_q.size() == 0)
          report_fail("a response appeared that nothing expected");
        else
          check({resp_lbl_q.pop_front(), " resp"}, 32'(exp_resp_q.pop_front()), 32'(resp));
      end
    end
    cmd_rdy_seen = cmd_rdy;                    // Rising edge detect
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers called at a falling edge
  ////////////////////////////////////////////////////////////////////////////
  task automatic send_serial(input logic [15:0] word);
    rx_byte = word[15:8];                      // High byte first
    rx_rdy  = 1'b1;
    @(negedge clk);
    rx_byte = word[7:0];
    @(negedge clk);
    rx_rdy  = 1'b0;
    rx_byte = 8'h00;
  endtask

  task automatic pulse_start();
    start_tour = 1'b1;
    @(negedge clk);
    start_tour = 1'b0;
  endtask

  task automatic load_table();
    for (int i = 0; i < `TOUR_MOVES; i++) begin
      load_we   = 1'b1;
      load_addr = 5'(i);
      load_move = table_q[i];
      @(negedge clk);
    end
    load_we = 1'b0;
  endtask

  task automatic wait_cmd_rdy();
    int n;
    n = 0;
    while (cmd_rdy !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (cmd_rdy !== 1'b1)
      report_fail("cmd_rdy never rose, timed out");
  endtask

  // Processor model takes one command, optionally stalls, then responds
  task automatic run_command(input logic [15:0] exp_cmd, input logic [7:0] exp_resp,
                             input string label, input int hold, input logic disturb);
    exp_cmd_q.push_back(exp_cmd);
    exp_resp_q.push_back(exp_resp);
    cmd_lbl_q.push_back(label);
    resp_lbl_q.push_back(label);
    wait_cmd_rdy();
    if (disturb) begin
      send_serial(SERIAL_MID);                 // Must stay pending until the tour ends
      pulse_start();                           // Ignored mid-tour
    end
    for (int k = 0; k < hold; k++) begin
      @(negedge clk);
      check({label, " held cmd"}, 32'(exp_cmd), 32'(cmd));
      check({label, " held cmd_rdy"}, 32'd1, 32'(cmd_rdy));
    end
    clr_cmd_rdy = 1'b1;
    @(negedge clk);
    clr_cmd_rdy = 1'b0;
    send_resp   = 1'b1;
    @(negedge clk);
    send_resp   = 1'b0;
    check({label, " resp_vld"}, 32'd1, 32'(resp_vld));   // One cycle after send_resp
    check({label, " cmd_rdy low"}, 32'd0, 32'(cmd_rdy));
  endtask

  task automatic run_tour(input logic disturb);
    logic [23:0] e;
    logic        stall;
    string       lbl;
    pulse_start();
    for (int idx = 0; idx < `TOUR_MOVES; idx++) begin
      for (int ph = 0; ph < 2; ph++) begin
        e     = expect_step(table_q[idx], (ph == 1), idx);
        stall = disturb && idx == 9 && ph == 0;
        lbl   = $sformatf("move %0d %s", idx, (ph == 1) ? "horz" : "vert");
        run_command(e[23:8], e[7:0], lbl, stall ? 20 : 0, stall);
      end
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err0 = errors;
  endtask

  task automatic finish_test();
    repeat (2) @(negedge clk);                 // Let the checker see the last response
    if (exp_cmd_q.size() != 0 || exp_resp_q.size() != 0)
      report_fail("expected commands or responses never appeared");
    exp_cmd_q.delete();
    exp_resp_q.delete();
    cmd_lbl_q.delete();
    resp_lbl_q.delete();
    tests++;
    $display("test %s %s, %0d errors", test_name,
             (errors == test_err0) ? "ok" : "bad", errors - test_err0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    rst_n        = 1'b0;
    rx_byte      = 8'h00;
    rx_rdy       = 1'b0;
    load_we      = 1'b0;
    load_addr    = '0;
    load_move    = 8'h01;
    start_tour   = 1'b0;
    clr_cmd_rdy  = 1'b0;
    send_resp    = 1'b0;
    cmd_rdy_seen = 1'b0;
    errors       = 0;
    tests        = 0;
    seed         = 60;

    begin_test("reset");
    repeat (4) begin
      @(negedge clk);
      check("cmd_rdy in reset", 32'd0, 32'(cmd_rdy));
      check("resp_vld in reset", 32'd0, 32'(resp_vld));
    end
    rst_n = 1'b1;
    @(negedge clk);
    check("cmd_rdy after reset", 32'd0, 32'(cmd_rdy));
    check("resp_vld after reset", 32'd0, 32'(resp_vld));
    finish_test();

    begin_test("serial");
    send_serial(SERIAL_CMD);
    run_command(SERIAL_CMD, `RESP_DONE, "serial", 0, 1'b0);
    finish_test();

    begin_test("random_tour");                 // Adds stalls, a mid-tour serial command and a restart
    for (int i = 0; i < `TOUR_MOVES; i++)
      table_q[i] = 8'h01 << ($random(seed) & 7);
    load_table();
    run_tour(1'b1);
    run_command(SERIAL_MID, `RESP_DONE, "pending serial", 0, 1'b0);
    finish_test();

    begin_test("all_moves");
    for (int i = 0; i < `TOUR_MOVES; i++)
      table_q[i] = 8'h01 << (i % 8);           // Each encoding three times
    load_table();
    run_tour(1'b0);
    finish_test();

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+rtl
rtl/tour_pkg.sv
rtl/cmd_byte_assembler.sv
rtl/move_store.sv
rtl/tour_cmd.sv
rtl/cmd_issue.sv
rtl/knight_tour_top.sv
testbench/tb_knight_tour.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the knight tour testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module tb_knight_tour \
  -Mdir "$BUILD_DIR" -o tb_knight_tour
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_knight_tour" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
  echo "Result: pass"
  exit 0
fi
echo "Result: fail"
exit 1
